/* Makefile */
# Verilator build and run of the pb_soc testbench
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_pb_soc
RTL_TOP    ?= pb_soc
FLIST      ?= pb_soc.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= CHECKS FAILED
PASS_MSG   ?= ALL CHECKS PASSED
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || grep -q "%Error" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
	   echo "Simulation result: failure, see $(LOG)"; \
	   exit 1; \
	fi
	@echo "Simulation result: success"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* pb_bus_pkg.sv */
// Types of the uncached peripheral bus
// A channel is valid/ready; a request with an all-zero mask is a read
// err in a response is only raised for unmapped addresses
`include "pb_soc_config.svh"

package pb_bus_pkg;

   // A channel payload, master to device
   typedef struct packed {
      logic [`PB_AW-1:0]   addr;       // Byte address
      logic [`PB_DW-1:0]   wdata;      // Write data
      logic [`PB_DW/8-1:0] wmsk;       // Byte enables, zero means read
   } pb_req_t;

   // B channel payload, device to master
   typedef struct packed {
      logic [`PB_DW-1:0]   rdata;      // Read data, zero on writes
      logic                err;        // Unmapped access
   } pb_rsp_t;

   // Decoded device behind the router
   typedef enum logic {
      TGT_NULL = 1'b0,                 // Unmapped window
      TGT_SPI  = 1'b1                  // SPI master window
   } pb_target_e;

endpackage

/* pb_router.sv */
// Peripheral bus router, one outstanding request at a time
// Decode and steering are combinational, so no cycles are added
// Unmapped requests get err=1 and zero data one cycle after acceptance
`timescale 1ns/10ps
`include "pb_soc_config.svh"

module pb_router
   import pb_bus_pkg::*;
(
   input  logic    CPU_CLK,
   input  logic    rst_sync_l,
   // Master side
   input  logic    m_a_valid,
   input  pb_req_t m_a,
   output logic    m_a_ready,
   output logic    m_b_valid,
   output pb_rsp_t m_b,
   input  logic    m_b_ready,
   // SPI master side
   output logic    s_a_valid,
   output pb_req_t s_a,
   input  logic    s_a_ready,
   input  logic    s_b_valid,
   input  pb_rsp_t s_b,
   output logic    s_b_ready
);

   localparam int ATOP = `PB_AW - 1;

   // Fixed answer of the null responder
   localparam pb_rsp_t NULL_RSP = '{rdata: '0, err: 1'b1};

   pb_target_e tgt_dec;                // Target of the request on A
   pb_target_e tgt_q;                  // Target of the outstanding request
   logic       pend_q;                 // Accepted, response not yet taken
   logic       null_vld_q;             // Null responder B valid
   logic       a_fire;
   logic       b_fire;

   // Address decode on the top byte
   assign tgt_dec = (m_a.addr[ATOP -: `PB_DECODE_BITS] == `PB_SPI_BASE) ?
                    TGT_SPI : TGT_NULL;

   // A channel steering
   assign s_a       = m_a;                                     // Payload to SPI as is
   assign s_a_valid = m_a_valid && !pend_q && (tgt_dec == TGT_SPI);
   assign m_a_ready = !pend_q &&
                      ((tgt_dec == TGT_NULL) || s_a_ready);    // Null always takes it
   assign a_fire    = m_a_valid && m_a_ready;

   // B channel return, selected by the remembered target
   assign m_b_valid = (tgt_q == TGT_SPI) ? s_b_valid : null_vld_q;
   assign m_b       = (tgt_q == TGT_SPI) ? s_b : NULL_RSP;
   assign s_b_ready = m_b_ready && (tgt_q == TGT_SPI);
   assign b_fire    = m_b_valid && m_b_ready;

   // Outstanding request tracking
   always_ff @(posedge CPU_CLK or negedge rst_sync_l) begin
      if (!rst_sync_l) begin
         pend_q     <= 1'b0;
         tgt_q      <= TGT_NULL;
         null_vld_q <= 1'b0;
      end else begin
         if (a_fire) begin
            pend_q     <= 1'b1;                    // Blocks A until B is taken
            tgt_q      <= tgt_dec;
            null_vld_q <= (tgt_dec == TGT_NULL);   // Null answers next cycle
         end else if (b_fire) begin
            pend_q     <= 1'b0;
            null_vld_q <= 1'b0;
         end
      end
   end

endmodule

/* pb_soc.f */
+incdir+.
pb_bus_pkg.sv
spi_pkg.sv
pb_router.sv
pb_spi_master.sv
pb_soc.sv
pb_soc_sva.sv
tb_pb_soc.sv

/* pb_soc.sv */
// Peripheral half of the SoC, reached through the uncached data bus port
// Map: 0x80xx_xxxx is the SPI master, every other window is unmapped
// RST_L may be asynchronous, it is released 2 CPU_CLK cycles after it rises
`timescale 1ns/10ps

module pb_soc
   import pb_bus_pkg::*;
(
   input  logic    CPU_CLK,
   input  logic    RST_L,
   // Master port
   input  logic    m_a_valid,
   input  pb_req_t m_a,
   output logic    m_a_ready,
   output logic    m_b_valid,
   output pb_rsp_t m_b,
   input  logic    m_b_ready,
   // SPI pins
   output logic    spi_sck,
   output logic    spi_cs_l,
   output logic    spi_mosi,
   input  logic    spi_miso
);

   logic [1:0] rst_sync_q;             // Reset synchronizer chain
   logic       rst_sync_l;
   logic       s_a_valid;
   pb_req_t    s_a;
   logic       s_a_ready;
   logic       s_b_valid;
   pb_rsp_t    s_b;
   logic       s_b_ready;

   // Async assert, sync release
   always_ff @(posedge CPU_CLK or negedge RST_L) begin
      if (!RST_L) begin
         rst_sync_q <= 2'b00;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b1};
      end
   end
   assign rst_sync_l = rst_sync_q[1];

   pb_router u_router (
      .CPU_CLK    (CPU_CLK),
      .rst_sync_l (rst_sync_l),
      .m_a_valid  (m_a_valid),
      .m_a        (m_a),
      .m_a_ready  (m_a_ready),
      .m_b_valid  (m_b_valid),
      .m_b        (m_b),
      .m_b_ready  (m_b_ready),
      .s_a_valid  (s_a_valid),
      .s_a        (s_a),
      .s_a_ready  (s_a_ready),
      .s_b_valid  (s_b_valid),
      .s_b        (s_b),
      .s_b_ready  (s_b_ready)
   );

   pb_spi_master u_spi (
      .CPU_CLK    (CPU_CLK),
      .rst_sync_l (rst_sync_l),
      .s_a_valid  (s_a_valid),
      .s_a        (s_a),
      .s_a_ready  (s_a_ready),
      .s_b_valid  (s_b_valid),
      .s_b        (s_b),
      .s_b_ready  (s_b_ready),
      .spi_sck    (spi_sck),
      .spi_cs_l   (spi_cs_l),
      .spi_mosi   (spi_mosi),
      .spi_miso   (spi_miso)
   );

endmodule

/* pb_soc_config.svh */
// Build-wide constants for the peripheral bus and the SPI master
// Bus widths are fixed at 32 bits, byte masks assume PB_DW is a multiple of 8
// The SPI divider is 8 bits wide, a value of 0 behaves as 1
`ifndef PB_SOC_CONFIG_SVH
`define PB_SOC_CONFIG_SVH

// Bus geometry
`define PB_AW 32                // Address width
`define PB_DW 32                // Data width

// Address map, decoded from the top address byte
//   0x80xx_xxxx  SPI master
//   others       null responder, err set
`define PB_DECODE_BITS 8        // Top bits looked at by the router
`define PB_SPI_BASE 8'h80       // SPI master window

// SPI master
`define SPI_XFER_BITS 8         // Bits per transfer
`define SPI_DIV_RESET 8'd2      // CPU cycles per SCK half-period after reset

`endif

/* pb_soc_sva.sv */
// Handshake and pin checks bound into pb_soc
// Bus checks are disabled while the synchronized reset is low
`timescale 1ns/10ps

module pb_soc_sva
   import pb_bus_pkg::*;
(
   input logic    CPU_CLK,
   input logic    rst_sync_l,
   input logic    m_a_valid,
   input logic    m_a_ready,
   input logic    m_b_valid,
   input pb_rsp_t m_b,
   input logic    m_b_ready,
   input logic    spi_sck,
   input logic    spi_cs_l
);

   logic pend_q;                       // Accepted, response not yet taken

   always_ff @(posedge CPU_CLK or negedge rst_sync_l) begin
      if (!rst_sync_l) begin
         pend_q <= 1'b0;
      end else if (m_a_valid && m_a_ready) begin
         pend_q <= 1'b1;
      end else if (m_b_valid && m_b_ready) begin
         pend_q <= 1'b0;
      end
   end

   // Response payload holds under back-pressure
   b_hold: assert property (@(posedge CPU_CLK) disable iff (!rst_sync_l)
      (m_b_valid && !m_b_ready) |=> (m_b_valid && $stable(m_b)))
      else $error("m_b_valid or m_b changed while m_b_ready was low");

   // One outstanding request
   a_block: assert property (@(posedge CPU_CLK) disable iff (!rst_sync_l)
      pend_q |-> !m_a_ready)
      else $error("m_a_ready high while a response is pending");

   sck_idle: assert property (@(posedge CPU_CLK) spi_cs_l |-> !spi_sck)
      else $error("spi_sck high while spi_cs_l is high");

   cs_after_rst: assert property (@(posedge CPU_CLK) $rose(rst_sync_l) |-> spi_cs_l)
      else $error("spi_cs_l low right after reset release");

endmodule

bind pb_soc pb_soc_sva u_sva (
   .CPU_CLK    (CPU_CLK),
   .rst_sync_l (rst_sync_l),
   .m_a_valid  (m_a_valid),
   .m_a_ready  (m_a_ready),
   .m_b_valid  (m_b_valid),
   .m_b        (m_b),
   .m_b_ready  (m_b_ready),
   .spi_sck    (spi_sck),
   .spi_cs_l   (spi_cs_l)
);

/* pb_spi_master.sv */
// SPI master on the peripheral bus, mode 0, MSB first
// Registers at +0x0 DATA, +0x4 STATUS, +0x8 CTRL, +0xC unused
// A DATA write during a transfer is stalled on A until the engine is idle
// SCK is forced low while CS is deasserted, the engine still runs
// B response is registered, one cycle after acceptance, err always 0
`timescale 1ns/10ps
`include "pb_soc_config.svh"

module pb_spi_master
   import pb_bus_pkg::*;
   import spi_pkg::*;
(
   input  logic    CPU_CLK,
   input  logic    rst_sync_l,
   // Bus side
   input  logic    s_a_valid,
   input  pb_req_t s_a,
   output logic    s_a_ready,
   output logic    s_b_valid,
   output pb_rsp_t s_b,
   input  logic    s_b_ready,
   // SPI pins
   output logic    spi_sck,
   output logic    spi_cs_l,
   output logic    spi_mosi,
   input  logic    spi_miso
);

   localparam int DW  = `PB_DW;
   localparam int XB  = `SPI_XFER_BITS;
   localparam int BCW = $clog2(XB);

   spi_reg_e       reg_sel;            // Register addressed on A
   spi_state_e     state_q;
   logic           is_wr;              // Any byte enabled
   logic           data_wr;            // Write to DATA on A
   logic           a_fire;
   logic           busy;
   logic           half_end;           // Last cycle of an SCK half-period
   logic           last_bit;           // Final bit of the transfer
   logic [7:0]     div_q;              // CTRL[7:0]
   logic           cs_en_q;            // CTRL[8]
   logic [7:0]     cnt_q;              // Cycles within half-period
   logic [BCW-1:0] bit_q;              // Bits shifted so far
   logic           sck_q;
   logic [XB-1:0]  tx_q;               // MSB drives MOSI
   logic [XB-1:0]  rx_q;
   logic [XB-1:0]  rx_byte_q;          // Last complete rx byte
   logic           b_vld_q;
   pb_rsp_t        rsp_q;
   logic [DW-1:0]  rd_data;

   assign reg_sel  = spi_reg_e'(s_a.addr[3:2]);
   assign is_wr    = |s_a.wmsk;
   assign data_wr  = is_wr && (reg_sel == SPI_REG_DATA);
   assign busy     = (state_q == SPI_SHIFT);
   assign half_end = ({1'b0, cnt_q} + 9'd1) >= {1'b0, div_q};   // Div 0 acts as 1
   assign last_bit = (bit_q == BCW'(XB - 1));

   // One outstanding response, DATA write waits for idle
   assign s_a_ready = !b_vld_q && !(data_wr && busy);
   assign a_fire    = s_a_valid && s_a_ready;

   assign s_b_valid = b_vld_q;
   assign s_b       = rsp_q;

   // Pins
   assign spi_cs_l = !cs_en_q;
   assign spi_sck  = sck_q && cs_en_q;   // Idle low outside CS
   assign spi_mosi = tx_q[XB-1];

   // Read mux
   always_comb begin
      case (reg_sel)
         SPI_REG_DATA:   rd_data = DW'(rx_byte_q);
         SPI_REG_STATUS: rd_data = DW'(busy);
         SPI_REG_CTRL:   rd_data = DW'({cs_en_q, div_q});
         default:        rd_data = '0;     // NONE
      endcase
   end

   // CTRL register and B valid
   always_ff @(posedge CPU_CLK or negedge rst_sync_l) begin
      if (!rst_sync_l) begin
         div_q   <= `SPI_DIV_RESET;
         cs_en_q <= 1'b0;
         b_vld_q <= 1'b0;
      end else begin
         if (a_fire && is_wr && (reg_sel == SPI_REG_CTRL)) begin
            if (s_a.wmsk[0]) div_q <= s_a.wdata[7:0];    // Byte 0
            if (s_a.wmsk[1]) cs_en_q <= s_a.wdata[8];    // Byte 1
         end
         if (a_fire) begin
            b_vld_q <= 1'b1;
         end else if (s_b_ready) begin
            b_vld_q <= 1'b0;
         end
      end
   end

   // Shift engine
   always_ff @(posedge CPU_CLK or negedge rst_sync_l) begin
      if (!rst_sync_l) begin
         state_q <= SPI_IDLE;
         cnt_q   <= '0;
         bit_q   <= '0;
         sck_q   <= 1'b0;
         tx_q    <= '0;
      end else begin
         case (state_q)
            SPI_IDLE: begin
               if (a_fire && data_wr) begin
                  state_q <= SPI_SHIFT;
                  cnt_q   <= '0;
                  bit_q   <= '0;
                  tx_q    <= s_a.wdata[XB-1:0];    // MSB out before first rise
               end
            end
            SPI_SHIFT: begin
               if (!half_end) begin
                  cnt_q <= cnt_q + 8'd1;
               end else begin
                  cnt_q <= '0;
                  sck_q <= !sck_q;
                  if (sck_q) begin                 // Falling edge
                     tx_q  <= {tx_q[XB-2:0], 1'b0};
                     bit_q <= bit_q + 1'b1;
                     if (last_bit) state_q <= SPI_IDLE;
                  end
               end
            end
         endcase
      end
   end

   // Receive path and response payload
   always_ff @(posedge CPU_CLK) begin
      if (busy && half_end && !sck_q) begin
         rx_q <= {rx_q[XB-2:0], spi_miso};         // Sample on rising SCK
      end
      if (busy && half_end && sck_q && last_bit) begin
         rx_byte_q <= rx_q;
      end
      if (a_fire) begin
         rsp_q.rdata <= is_wr ? '0 : rd_data;      // Writes return zero
         rsp_q.err   <= 1'b0;
      end
   end

endmodule

/* spi_pkg.sv */
// Types of the SPI master controller
// Register select comes from address bits 3:2 of the bus request

package spi_pkg;

   // Register map, word aligned
   typedef enum logic [1:0] {
      SPI_REG_DATA   = 2'd0,           // 0x0 tx on write, rx on read
      SPI_REG_STATUS = 2'd1,           // 0x4 bit 0 busy
      SPI_REG_CTRL   = 2'd2,           // 0x8 divider and CS
      SPI_REG_NONE   = 2'd3            // 0xC reads zero
   } spi_reg_e;

   // Shift engine
   typedef enum logic {
      SPI_IDLE  = 1'b0,
      SPI_SHIFT = 1'b1
   } spi_state_e;

endpackage

/* tb_pb_soc.sv */
// Directed testbench for pb_soc with a mode-0 SPI slave model on the pins
// Inputs change on the falling CPU_CLK edge, outputs are sampled 1 ns later
// The slave answers each transfer with a new random byte, keeps what it saw and times SCK
// The run stops at MAX_CYCLES CPU_CLK cycles
`timescale 1ns/10ps
`include "pb_soc_config.svh"

module tb_pb_soc
   import pb_bus_pkg::*;
   import spi_pkg::*;
();

   localparam int MAX_CYCLES = 6000;   // 12 transfers at div 8 plus bus traffic

   logic       CPU_CLK;
   logic       RST_L;
   logic       m_a_valid;
   pb_req_t    m_a;
   logic       m_a_ready;
   logic       m_b_valid;
   pb_rsp_t    m_b;
   logic       m_b_ready;
   logic       spi_sck;
   logic       spi_cs_l;
   logic       spi_mosi;
   logic       spi_miso = 1'b0;

   integer     seed = 32'h7451_5e7c;   // Shared by slave and tests
   int         cycle_cnt = 0;
   int         err_cnt = 0;
   int         test_cnt = 0;
   int         test_fail = 0;
   logic [8:0] ctrl_exp;               // Expected CTRL contents
   logic [7:0] slv_tx;                 // Slave byte on MISO
   logic [7:0] slv_rx;                 // Slave shift from MOSI
   int         slv_bit;                // Bits done in current transfer
   int         slv_t0;                 // Cycle of the first rising SCK
   int         slv_span;               // First rise to last fall, in cycles
   logic [7:0] mosi_q[$];              // Bytes the slave received
   logic [7:0] miso_q[$];              // Bytes the slave sent

   pb_soc u_pb_soc (
      .CPU_CLK   (CPU_CLK),
      .RST_L     (RST_L),
      .m_a_valid (m_a_valid),
      .m_a       (m_a),
      .m_a_ready (m_a_ready),
      .m_b_valid (m_b_valid),
      .m_b       (m_b),
      .m_b_ready (m_b_ready),
      .spi_sck   (spi_sck),
      .spi_cs_l  (spi_cs_l),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso)
   );

   initial begin
      CPU_CLK = 1'b0;
      forever #2 CPU_CLK = ~CPU_CLK;   // 4 ns period
   end

   always @(posedge CPU_CLK) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Run stopped by the timeout after %0d cycles", cycle_cnt);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // SPI slave, mode 0, MSB first
   always @(negedge CPU_CLK) spi_miso <= slv_tx[7 - slv_bit];

   always @(posedge spi_sck) begin
      if (!spi_cs_l) begin
         slv_rx = {slv_rx[6:0], spi_mosi};               // Capture on rise
         if (slv_bit == 0) slv_t0 = cycle_cnt;           // Start of the byte
      end
   end

   initial begin
      slv_bit  = 0;
      slv_t0   = 0;
      slv_span = 0;
      slv_rx   = 8'h00;
      slv_tx   = 8'($random(seed));
      forever begin
         @(negedge spi_sck);
         if (!spi_cs_l) begin
            if (slv_bit == `SPI_XFER_BITS - 1) begin   // Byte complete
               mosi_q.push_back(slv_rx);
               miso_q.push_back(slv_tx);
               slv_span = cycle_cnt - slv_t0;
               slv_tx   = 8'($random(seed));
               slv_bit  = 0;
            end else begin
               slv_bit++;
            end
         end
      end
   end

   function automatic logic [`PB_AW-1:0] spi_addr(input spi_reg_e r);
      return {`PB_SPI_BASE, {(`PB_AW - `PB_DECODE_BITS - 4){1'b0}}, r, 2'b00};
   endfunction

   function automatic pb_rsp_t rsp_of(input logic [`PB_DW-1:0] data, input logic err);
      pb_rsp_t r;
      r.rdata = data;
      r.err   = err;
      return r;
   endfunction

   task automatic check_rsp(input string name, input pb_rsp_t got, input pb_rsp_t exp);
      if (got !== exp) begin
         $display("FAIL %s rdata=%h err=%h expected rdata=%h err=%h",
                  name, got.rdata, got.err, exp.rdata, exp.err);
         err_cnt++;
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got=%h expected=%h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_pin(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s got=%h expected=%h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      test_cnt++;
      if (err_cnt == err_start) begin
         $display("Test %s: ok", name);
      end else begin
         test_fail++;
         $display("Test %s: %0d errors", name, err_cnt - err_start);
      end
   endtask

   // One A/B exchange, B held off for hold cycles
   task automatic bus_access(input pb_req_t req, input int hold, output pb_rsp_t rsp);
      pb_rsp_t first;
      @(negedge CPU_CLK);
      m_a_valid = 1'b1;
      m_a       = req;
      #1;
      while (!m_a_ready) begin
         @(negedge CPU_CLK);
         #1;
      end
      @(negedge CPU_CLK);                      // Accepted on the edge just passed
      m_a_valid = 1'b0;
      #1;
      if (!m_b_valid) begin
         $display("Response was not valid one cycle after the request was accepted");
         err_cnt++;
      end
      first = m_b;
      repeat (hold) begin
         @(negedge CPU_CLK);
         #1;
         if (!m_b_valid || (m_b !== first) || m_a_ready) begin
            $display("Response or A-ready changed while the response was held off");
            err_cnt++;
         end
      end
      @(negedge CPU_CLK);
      m_b_ready = 1'b1;
      #1;
      while (!m_b_valid) begin
         @(negedge CPU_CLK);
         #1;
      end
      rsp = m_b;
      @(negedge CPU_CLK);                      // Taken on the edge just passed
      m_b_ready = 1'b0;
   endtask

   task automatic bus_write(input logic [`PB_AW-1:0] addr, input logic [`PB_DW-1:0] data,
                            input logic [`PB_DW/8-1:0] mask, output pb_rsp_t rsp);
      pb_req_t req;
      req.addr  = addr;
      req.wdata = data;
      req.wmsk  = mask;
      bus_access(req, 0, rsp);
   endtask

   task automatic bus_read(input logic [`PB_AW-1:0] addr, output pb_rsp_t rsp);
      pb_req_t req;
      req.addr  = addr;
      req.wdata = '0;
      req.wmsk  = '0;                          // Zero mask is a read
      bus_access(req, 0, rsp);
   endtask

   task automatic ctrl_write(input logic [`PB_DW-1:0] data, input logic [`PB_DW/8-1:0] mask);
      pb_rsp_t rsp;
      bus_write(spi_addr(SPI_REG_CTRL), data, mask, rsp);
      check_rsp("m_b CTRL write", rsp, rsp_of('0, 1'b0));
      if (mask[0]) ctrl_exp[7:0] = data[7:0];
      if (mask[1]) ctrl_exp[8] = data[8];
   endtask

   task automatic wait_idle();
      pb_rsp_t rsp;
      do begin
         bus_read(spi_addr(SPI_REG_STATUS), rsp);
         check_pin("m_b.err STATUS", rsp.err, 1'b0);
      end while (rsp.rdata[0]);
   endtask

   task automatic spi_xfer(input logic [7:0] tx);
      pb_rsp_t rsp;
      bus_write(spi_addr(SPI_REG_DATA), 32'(tx), 4'b0001, rsp);
      check_rsp("m_b DATA write", rsp, rsp_of('0, 1'b0));
      wait_idle();
      if ((mosi_q.size() != 1) || (miso_q.size() != 1)) begin
         $display("Slave model did not see exactly one byte for the transfer");
         err_cnt++;
      end else begin
         check_byte("spi_mosi byte", mosi_q.pop_front(), tx);
         bus_read(spi_addr(SPI_REG_DATA), rsp);
         check_rsp("m_b DATA read", rsp, rsp_of(32'(miso_q.pop_front()), 1'b0));
      end
   endtask

   task automatic test_reset();
      int      err_start;
      pb_rsp_t rsp;
      err_start = err_cnt;
      ctrl_exp  = {1'b0, `SPI_DIV_RESET};
      #1;
      check_pin("m_a_ready", m_a_ready, 1'b1);
      check_pin("m_b_valid", m_b_valid, 1'b0);
      check_pin("spi_cs_l", spi_cs_l, 1'b1);
      check_pin("spi_sck", spi_sck, 1'b0);
      bus_read(spi_addr(SPI_REG_CTRL), rsp);
      check_rsp("m_b CTRL read", rsp, rsp_of(32'(ctrl_exp), 1'b0));
      bus_read(spi_addr(SPI_REG_STATUS), rsp);
      check_rsp("m_b STATUS read", rsp, rsp_of('0, 1'b0));
      bus_read(spi_addr(SPI_REG_NONE), rsp);
      check_rsp("m_b NONE read", rsp, rsp_of('0, 1'b0));
      report_test("reset_values", err_start);
   endtask

   task automatic test_ctrl_mask();
      int         err_start;
      pb_rsp_t    rsp;
      logic [8:0] wr [3] = '{9'h104, 9'h0AB, 9'h1FF};
      logic [3:0] mk [3] = '{4'b1111, 4'b0010, 4'b0010};
      err_start = err_cnt;
      for (int i = 0; i < 3; i++) begin
         ctrl_write(32'(wr[i]), mk[i]);
         bus_read(spi_addr(SPI_REG_CTRL), rsp);
         check_rsp("m_b CTRL read", rsp, rsp_of(32'(ctrl_exp), 1'b0));
         check_pin("spi_cs_l", spi_cs_l, !ctrl_exp[8]);   // Follows bit 8
      end
      report_test("ctrl_byte_mask", err_start);
   endtask

   task automatic test_transfers();
      int         err_start;
      logic [7:0] div;
      err_start = err_cnt;
      for (int i = 0; i < 2; i++) begin
         div = (i == 0) ? 8'd2 : 8'd5;
         ctrl_write({23'd0, 1'b1, div}, 4'b0011);          // CS on
         repeat (3) begin
            spi_xfer(8'($random(seed)));
            check_byte("spi_sck cycles per byte", 8'(slv_span),
                       8'((2 * `SPI_XFER_BITS - 1) * div));   // First low half not counted
         end
      end
      report_test("spi_transfers", err_start);
   endtask

   task automatic test_unmapped();
      int               err_start;
      pb_rsp_t          rsp;
      logic [`PB_AW-1:0] addrs [4] = '{32'h8100_0008, 32'h0000_0000,
                                       32'h7F00_0004, 32'hFF80_0008};
      err_start = err_cnt;
      foreach (addrs[i]) begin
         bus_read(addrs[i], rsp);
         check_rsp("m_b unmapped read", rsp, rsp_of('0, 1'b1));
         bus_write(addrs[i], 32'h0000_00FF, 4'b1111, rsp);
         check_rsp("m_b unmapped write", rsp, rsp_of('0, 1'b1));
      end
      bus_read(spi_addr(SPI_REG_CTRL), rsp);
      check_rsp("m_b CTRL read", rsp, rsp_of(32'(ctrl_exp), 1'b0));
      check_pin("spi_cs_l", spi_cs_l, !ctrl_exp[8]);
      report_test("unmapped_addresses", err_start);
   endtask

   task automatic test_backpressure();
      int         err_start;
      pb_rsp_t    rsp;
      pb_req_t    req;
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] rx1;
      err_start = err_cnt;
      ctrl_write(32'h0000_0102, 4'b0011);
      req.addr  = spi_addr(SPI_REG_CTRL);
      req.wdata = '0;
      req.wmsk  = '0;
      bus_access(req, 10, rsp);                            // SPI path held
      check_rsp("m_b held CTRL read", rsp, rsp_of(32'(ctrl_exp), 1'b0));
      req.addr = 32'h8100_0000;
      bus_access(req, 10, rsp);                            // Null path held
      check_rsp("m_b held unmapped read", rsp, rsp_of('0, 1'b1));
      b0 = 8'($random(seed));
      b1 = 8'($random(seed));
      bus_write(spi_addr(SPI_REG_DATA), 32'(b0), 4'b0001, rsp);
      check_rsp("m_b DATA write", rsp, rsp_of('0, 1'b0));
      bus_write(spi_addr(SPI_REG_DATA), 32'(b1), 4'b0001, rsp);   // Stalls on A
      check_rsp("m_b DATA write", rsp, rsp_of('0, 1'b0));
      if (mosi_q.size() != 1) begin
         $display("Second DATA write was accepted before the first transfer ended");
         err_cnt++;
      end
      wait_idle();
      if ((mosi_q.size() != 2) || (miso_q.size() != 2)) begin
         $display("Slave model did not see both bytes of the back-to-back writes");
         err_cnt++;
      end else begin
         check_byte("spi_mosi first byte", mosi_q.pop_front(), b0);
         check_byte("spi_mosi second byte", mosi_q.pop_front(), b1);
         rx1 = miso_q.pop_front();
         rx1 = miso_q.pop_front();                         // Last byte wins
         bus_read(spi_addr(SPI_REG_DATA), rsp);
         check_rsp("m_b DATA read", rsp, rsp_of(32'(rx1), 1'b0));
      end
      report_test("back_pressure", err_start);
   endtask

   initial begin
      RST_L     = 1'b0;
      m_a_valid = 1'b0;
      m_a       = '0;
      m_b_ready = 1'b0;
      repeat (16) @(negedge CPU_CLK);
      RST_L = 1'b1;
      repeat (3) @(negedge CPU_CLK);                      // Synchronizer release
      test_reset();
      test_ctrl_mask();
      test_transfers();
      test_unmapped();
      test_backpressure();
      $display("Tests run %0d, tests failed %0d, check errors %0d",
               test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
